// ==== sources.f ====
rtl/pad_test_pkg.sv
rtl/frame_rom.sv
rtl/stream_table.sv
rtl/xfer_fsm.sv
rtl/chip_reset_seq.sv
rtl/pad_test_top.sv
bench/pad_test_asserts.sv
bench/tb_pad_test.sv

// ==== bench/tb_pad_test.sv ====
`timescale 1ns/1ps

module tb_pad_test;

    localparam int CLK_PERIOD      = 4;
    localparam int ROM_AW          = 14;
    localparam int RST_HOLD_CYCLES = 16;
    localparam int LOAD_WORDS      = 8704;              // all regions back to back
    localparam int ALL_STREAMS     = 2294;              // one burst of every stream
    localparam int BURST_WORDS     = 2 * ALL_STREAMS + 13 * 512 + 3 * 64;
    localparam int NUM_REQS        = 36;
    localparam int WATCHDOG_CYCLES = LOAD_WORDS + BURST_WORDS + NUM_REQS * 16 + 2000;

    logic                clk;
    logic                rst_n;
    logic                config_req;
    logic                switch_rdwr;
    pad_test_pkg::word_t spi_din;
    pad_test_pkg::word_t spi_dout;
    logic                oe_n;
    logic                cs_n;
    logic                chip_rst_n;
    logic                chip_clk_en;
    logic                load_en;
    logic [ROM_AW-1:0]   load_addr;
    pad_test_pkg::word_t load_data;
    logic                chip_reset_req;

    pad_test_pkg::word_t mem_copy [0:LOAD_WORDS-1];
    logic [31:0]         lfsr_q = 32'd92056;
    int                  ref_base  [8];
    int                  ref_len   [8];
    int                  ref_blk   [8];
    int                  ref_start [8];
    int                  cur_code;
    int                  word_idx;      // word position inside the running burst
    logic                cs_n_prev;     // chip select one cycle earlier

    pad_test_top #(.ROM_AW(ROM_AW), .RST_HOLD_CYCLES(RST_HOLD_CYCLES)) i_pad_test_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .config_req    (config_req),
        .switch_rdwr   (switch_rdwr),
        .spi_din       (spi_din),
        .spi_dout      (spi_dout),
        .oe_n          (oe_n),
        .cs_n          (cs_n),
        .chip_rst_n    (chip_rst_n),
        .chip_clk_en   (chip_clk_en),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .chip_reset_req(chip_reset_req)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================================
    // random source, 32 bit fibonacci, taps 32 22 2 1
    // ==================================================================
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic pad_test_pkg::word_t random_word();
        pad_test_pkg::word_t w;
        for (int i = 0; i < pad_test_pkg::WORD_W; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    // ==================================================================
    // reference model
    // ==================================================================
    // index is the stream code, CFG FLGOFM OFM WEIADDR WEI FLGWEI ACT FLGACT
    task automatic set_region_table();
        ref_base  = '{0, 8640, 8384, 64, 704, 192, 3776, 1728};
        ref_len   = '{64, 64, 64, 54, 512, 512, 512, 512};
        ref_blk   = '{1, 1, 4, 2, 2, 1, 9, 4};
        ref_start = ref_base;
    endtask

    function automatic pad_test_pkg::word_t expected_word(int code, int k);
        return mem_copy[ref_start[code] + k];
    endfunction

    function automatic void advance_start(int code);
        int off;
        off = ref_start[code] - ref_base[code] + ref_len[code];
        if (off >= ref_len[code] * ref_blk[code]) begin
            off = off - ref_len[code] * ref_blk[code];  // wrap inside the region
        end
        ref_start[code] = ref_base[code] + off;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERR time=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // every cycle with chip select low carries one word
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("oe_n", oe_n, cs_n && cs_n_prev);  // trails chip select by one
            if (!cs_n) begin
                if (word_idx >= ref_len[cur_code]) begin
                    fail_run("chip select stayed low past the burst length");
                end
                check_value("spi_dout", spi_dout, expected_word(cur_code, word_idx));
                word_idx++;
            end
        end
        cs_n_prev = cs_n;
    end

    always @(posedge clk) begin
        if (i_pad_test_top.i_pad_test_asserts.fail_cnt != 0) begin
            fail_run("a bound assertion failed");
        end
    end

    // ==================================================================
    // stimulus tasks
    // ==================================================================
    task automatic load_memory();
        pad_test_pkg::word_t w;
        for (int a = 0; a < LOAD_WORDS; a++) begin
            w           = random_word();
            mem_copy[a] = w;
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= ROM_AW'(a);
            load_data <= w;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic run_burst(input int code, input logic rdwr);
        pad_test_pkg::word_t din;
        int                  cyc;
        din = random_word();
        din[pad_test_pkg::CODE_LSB +: 4] = 4'(code);
        @(posedge clk);
        cur_code = code;
        word_idx = 0;
        config_req  <= 1'b1;
        switch_rdwr <= rdwr;
        spi_din     <= din;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
            if (cyc > 20) fail_run("no chip select after a valid stream request");
        end while (cs_n);
        while (!cs_n) begin
            @(negedge clk);
            cyc++;
            if (cyc > ref_len[code] + 40) fail_run("chip select never returned high");
        end
        check_value("burst length", word_idx, ref_len[code]);
        @(posedge clk);
        config_req <= 1'b0;
        repeat (2) @(posedge clk);      // let the request re-arm
        if (rdwr) begin
            advance_start(code);
        end
    endtask

    task automatic unknown_code_check(input int code);
        pad_test_pkg::word_t din;
        din = random_word();
        din[pad_test_pkg::CODE_LSB +: 4] = 4'(code);
        @(posedge clk);
        config_req  <= 1'b1;
        switch_rdwr <= 1'b1;
        spi_din     <= din;
        repeat (10) begin
            @(negedge clk);
            check_value("cs_n", cs_n, 1'b1);
        end
        @(posedge clk);
        config_req <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic chip_reset_check();
        int clk_off_at;
        int rst_low_at;
        int rst_high_at;
        int clk_on_at;
        clk_off_at  = -1;
        rst_low_at  = -1;
        rst_high_at = -1;
        clk_on_at   = -1;
        @(posedge clk);
        chip_reset_req <= 1'b1;
        @(posedge clk);
        chip_reset_req <= 1'b0;
        for (int cyc = 0; cyc < RST_HOLD_CYCLES + 12; cyc++) begin
            @(negedge clk);
            if (!chip_clk_en && clk_off_at < 0) clk_off_at = cyc;
            if (!chip_rst_n && rst_low_at < 0) rst_low_at = cyc;
            if (chip_rst_n && rst_low_at >= 0 && rst_high_at < 0) rst_high_at = cyc;
            if (chip_clk_en && clk_off_at >= 0 && clk_on_at < 0) clk_on_at = cyc;
        end
        if (clk_off_at < 0 || rst_high_at < 0 || clk_on_at < 0) begin
            fail_run("chip reset sequence did not complete");
        end
        check_value("clk_en falls before chip_rst_n", rst_low_at > clk_off_at, 1'b1);
        check_value("chip_rst_n low cycles", rst_high_at - rst_low_at, RST_HOLD_CYCLES);
        check_value("clk_en rises after chip_rst_n", clk_on_at > rst_high_at, 1'b1);
        ref_start = ref_base;           // every stream rewinds
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        config_req     = 1'b0;
        switch_rdwr    = 1'b1;
        spi_din        = '0;
        load_en        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        chip_reset_req = 1'b0;
        cur_code       = 0;
        word_idx       = 0;
        cs_n_prev      = 1'b1;
        set_region_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        load_memory();
        for (int c = 0; c < 8; c++) begin
            run_burst(c, 1'b1);
        end
        chip_reset_check();
        for (int c = 0; c < 8; c++) begin   // all from the region base again
            run_burst(c, 1'b1);
        end
        repeat (3) run_burst(pad_test_pkg::WEI, 1'b1);     // 1216 704 1216
        repeat (10) run_burst(pad_test_pkg::ACT, 1'b1);    // wraps after nine
        run_burst(pad_test_pkg::OFM, 1'b0);
        run_burst(pad_test_pkg::OFM, 1'b1);     // same words as the write burst
        unknown_code_check(12);
        run_burst(pad_test_pkg::CFG, 1'b1);
        repeat (4) @(posedge clk);
        if (i_pad_test_top.i_pad_test_asserts.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("bound assertions failed %0d times",
                     i_pad_test_top.i_pad_test_asserts.fail_cnt);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

endmodule

// ==== bench/pad_test_asserts.sv ====
`timescale 1ns/1ps

module pad_test_asserts (
    input logic clk,
    input logic rst_n,
    input logic cs_n,
    input logic oe_n,
    input logic chip_rst_n,
    input logic chip_clk_en
);

    int unsigned fail_cnt = 0;  // read by the testbench at the end

    // ==================================================================
    // pad and chip reset rules
    // ==================================================================
    cs_needs_oe: assert property (@(posedge clk) disable iff (!rst_n) !cs_n |-> !oe_n)
        else begin
            $error("cs_n low while oe_n high");
            fail_cnt++;
        end

    // clock gated for the whole reset pulse
    rst_needs_clk_off: assert property (@(posedge clk) disable iff (!rst_n)
        !chip_rst_n |-> !chip_clk_en)
        else begin
            $error("chip_rst_n low with chip clock running");
            fail_cnt++;
        end

    no_cs_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cs_n) |-> chip_rst_n)
        else begin
            $error("cs_n fell during chip reset");
            fail_cnt++;
        end

endmodule

bind pad_test_top pad_test_asserts i_pad_test_asserts (
    .clk(clk), .rst_n(rst_n), .cs_n(cs_n), .oe_n(oe_n),
    .chip_rst_n(chip_rst_n), .chip_clk_en(chip_clk_en)
);

// ==== rtl/pad_test_top.sv ====
`timescale 1ns/1ps

module pad_test_top #(
    parameter int ROM_AW          = 14,
    parameter int RST_HOLD_CYCLES = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // chip side
    input  logic                 config_req,
    input  logic                 switch_rdwr,
    input  pad_test_pkg::word_t  spi_din,
    output pad_test_pkg::word_t  spi_dout,
    output logic                 oe_n,
    output logic                 cs_n,
    output logic                 chip_rst_n,
    output logic                 chip_clk_en,
    // host side
    input  logic                 load_en,
    input  logic [ROM_AW-1:0]    load_addr,
    input  pad_test_pkg::word_t  load_data,
    input  logic                 chip_reset_req
);

    pad_test_pkg::stream_code_e            code;
    logic                                  burst_done;
    logic [ROM_AW-1:0]                     start_addr;
    logic [pad_test_pkg::LEN_W-1:0]        burst_len;
    logic [ROM_AW-1:0]                     rom_addr;
    logic                                  rom_en;
    pad_test_pkg::word_t                   rom_word;

    if (ROM_AW < pad_test_pkg::ROM_AW_MIN) begin : g_aw_check
        $error("ROM_AW too small for the stream regions");
    end

    // ==================================================================
    // transfer path
    // ==================================================================
    xfer_fsm #(.ROM_AW(ROM_AW)) i_xfer_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .chip_rst_n (chip_rst_n),
        .config_req (config_req),
        .switch_rdwr(switch_rdwr),
        .spi_din    (spi_din),
        .start_addr (start_addr),
        .burst_len  (burst_len),
        .rom_word   (rom_word),
        .code       (code),
        .burst_done (burst_done),
        .rom_addr   (rom_addr),
        .rom_en     (rom_en),
        .spi_dout   (spi_dout),
        .oe_n       (oe_n),
        .cs_n       (cs_n)
    );

    stream_table #(.ROM_AW(ROM_AW)) i_stream_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .chip_rst_n (chip_rst_n),
        .code       (code),
        .burst_done (burst_done),
        .start_addr (start_addr),
        .burst_len  (burst_len)
    );

    frame_rom #(.ROM_AW(ROM_AW)) i_frame_rom (
        .clk      (clk),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .rd_en    (rom_en),
        .rd_addr  (rom_addr),
        .rd_data  (rom_word)
    );

    // chip reset also rewinds the stream table
    chip_reset_seq #(.RST_HOLD_CYCLES(RST_HOLD_CYCLES)) i_chip_reset_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .chip_reset_req(chip_reset_req),
        .chip_rst_n    (chip_rst_n),
        .chip_clk_en   (chip_clk_en)
    );

endmodule

// ==== rtl/chip_reset_seq.sv ====
`timescale 1ns/1ps

module chip_reset_seq #(
    parameter int RST_HOLD_CYCLES = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic chip_reset_req,    // one-cycle pulse
    output logic chip_rst_n,
    output logic chip_clk_en
);

    localparam int CNT_W = $clog2(RST_HOLD_CYCLES + 1);

    pad_test_pkg::rst_state_e state;
    pad_test_pkg::rst_state_e next_state;

    logic [CNT_W-1:0] hold_cnt;
    logic             hold_done;

    assign hold_done = (hold_cnt == CNT_W'(RST_HOLD_CYCLES - 1));

    // ==================================================================
    // clock off, reset pulse, clock on
    // ==================================================================
    always_comb begin
        next_state = state;
        case (state)
            pad_test_pkg::IDLE_RST: begin
                if (chip_reset_req) begin
                    next_state = pad_test_pkg::CLK_OFF;
                end
            end
            pad_test_pkg::CLK_OFF:  next_state = pad_test_pkg::RST_LOW;
            pad_test_pkg::RST_LOW: begin
                if (hold_done) begin
                    next_state = pad_test_pkg::RST_HIGH;
                end
            end
            pad_test_pkg::RST_HIGH: next_state = pad_test_pkg::CLK_ON;
            pad_test_pkg::CLK_ON:   next_state = pad_test_pkg::IDLE_RST;
            default:                next_state = pad_test_pkg::IDLE_RST;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= pad_test_pkg::IDLE_RST;
            hold_cnt    <= '0;
            chip_rst_n  <= 1'b1;
            chip_clk_en <= 1'b1;
        end else begin
            state    <= next_state;
            hold_cnt <= (state == pad_test_pkg::RST_LOW) ? hold_cnt + CNT_W'(1) : '0;
            // registered pins, no decode glitches toward the chip
            chip_rst_n  <= (next_state != pad_test_pkg::RST_LOW);
            chip_clk_en <= (next_state == pad_test_pkg::IDLE_RST) ||
                           (next_state == pad_test_pkg::CLK_ON);
        end
    end

endmodule

// ==== rtl/xfer_fsm.sv ====
`timescale 1ns/1ps

module xfer_fsm #(
    parameter int ROM_AW = 14
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            chip_rst_n,
    input  logic                            config_req,
    input  logic                            switch_rdwr,    // 1 read, 0 write
    input  pad_test_pkg::word_t             spi_din,
    input  logic [ROM_AW-1:0]               start_addr,
    input  logic [pad_test_pkg::LEN_W-1:0]  burst_len,
    input  pad_test_pkg::word_t             rom_word,
    output pad_test_pkg::stream_code_e      code,
    output logic                            burst_done,
    output logic [ROM_AW-1:0]               rom_addr,
    output logic                            rom_en,
    output pad_test_pkg::word_t             spi_dout,
    output logic                            oe_n,
    output logic                            cs_n
);

    localparam int CW = pad_test_pkg::LEN_W + 1;

    pad_test_pkg::xfer_state_e state;
    pad_test_pkg::xfer_state_e next_state;

    logic          req_q;
    logic          req_armed;   // request must drop before the next one counts
    logic          rdwr_q;
    logic          desc_valid;
    logic [CW-1:0] cnt;         // 0 in CONFIG, k+2 on word k
    logic [CW-1:0] last_cnt;

    assign desc_valid = pad_test_pkg::STREAM_DESC[code].valid;
    assign last_cnt   = {1'b0, burst_len} + CW'(1);

    // ==================================================================
    // state machine
    // ==================================================================
    always_comb begin
        next_state = state;
        case (state)
            pad_test_pkg::IDLE: begin
                if (req_q && req_armed) begin
                    next_state = pad_test_pkg::CONFIG;
                end
            end
            pad_test_pkg::CONFIG: begin
                // unknown code ends the exchange here
                next_state = desc_valid ? pad_test_pkg::WAIT : pad_test_pkg::IDLE;
            end
            pad_test_pkg::WAIT: next_state = pad_test_pkg::RD_DATA;
            pad_test_pkg::RD_DATA: begin
                if (cnt == last_cnt) begin
                    next_state = pad_test_pkg::IDLE;
                end
            end
            default: next_state = pad_test_pkg::IDLE;
        endcase
        if (!chip_rst_n) begin
            next_state = pad_test_pkg::IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= pad_test_pkg::IDLE;
            req_q     <= 1'b0;
            req_armed <= 1'b1;
            rdwr_q    <= 1'b0;
            code      <= pad_test_pkg::CFG;
            cnt       <= '0;
            cs_n      <= 1'b1;
            oe_n      <= 1'b1;
        end else begin
            req_q <= config_req;
            state <= next_state;
            if (next_state == pad_test_pkg::CONFIG) begin
                code      <= pad_test_pkg::stream_code_e'(spi_din[pad_test_pkg::CODE_LSB +: 4]);
                rdwr_q    <= switch_rdwr;
                req_armed <= 1'b0;
            end else if (!req_q) begin
                req_armed <= 1'b1;
            end
            if (state == pad_test_pkg::IDLE || next_state == pad_test_pkg::IDLE) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + CW'(1);
            end
            cs_n <= (next_state != pad_test_pkg::RD_DATA);
            // pad stays driven one cycle past the last word
            oe_n <= !(next_state == pad_test_pkg::RD_DATA || state == pad_test_pkg::RD_DATA);
        end
    end

    // ==================================================================
    // memory reads two cycles ahead of the pad
    // ==================================================================
    assign rom_en     = (state != pad_test_pkg::IDLE) && (cnt < {1'b0, burst_len});
    assign rom_addr   = start_addr + ROM_AW'(cnt);
    assign burst_done = (state == pad_test_pkg::RD_DATA) && (cnt == last_cnt) && rdwr_q;

    always_ff @(posedge clk) begin
        if (next_state == pad_test_pkg::RD_DATA) begin
            spi_dout <= rom_word;
        end
    end

endmodule

// ==== rtl/stream_table.sv ====
`timescale 1ns/1ps

module stream_table #(
    parameter int ROM_AW = 14
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            chip_rst_n,
    input  pad_test_pkg::stream_code_e      code,
    input  logic                            burst_done,
    output logic [ROM_AW-1:0]               start_addr,
    output logic [pad_test_pkg::LEN_W-1:0]  burst_len
);

    localparam int NS    = pad_test_pkg::NUM_STREAMS;
    localparam int IDX_W = $clog2(NS);
    localparam int SW    = ROM_AW + pad_test_pkg::BLK_W;   // holds len * blocks

    pad_test_pkg::stream_desc_t desc;

    logic [IDX_W-1:0]  idx;
    logic [ROM_AW-1:0] start_q [NS];    // one running start per stream
    logic [SW-1:0]     span;            // region size seen by the wrap
    logic [SW-1:0]     offset;
    logic [SW-1:0]     next_off;
    logic [SW-1:0]     wrap_off;
    logic [ROM_AW-1:0] next_start;

    // ==================================================================
    // descriptor lookup
    // ==================================================================
    assign desc = pad_test_pkg::STREAM_DESC[code];
    assign idx  = code[IDX_W-1:0];

    assign start_addr = start_q[idx];
    assign burst_len  = desc.len;   // zero for unknown codes

    // ==================================================================
    // circular advance
    // ==================================================================
    assign span     = SW'(desc.len) * SW'(desc.blocks);
    assign offset   = SW'(start_q[idx]) - SW'(desc.base);
    assign next_off = offset + SW'(desc.len);

    always_comb begin
        if (next_off >= span) begin
            wrap_off = next_off - span;     // back to the region start
        end else begin
            wrap_off = next_off;
        end
    end

    assign next_start = ROM_AW'(SW'(desc.base) + wrap_off);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NS; i++) begin
                start_q[i] <= ROM_AW'(pad_test_pkg::STREAM_DESC[i].base);
            end
        end else if (!chip_rst_n) begin
            // chip reset rewinds every stream
            for (int i = 0; i < NS; i++) begin
                start_q[i] <= ROM_AW'(pad_test_pkg::STREAM_DESC[i].base);
            end
        end else if (burst_done) begin
            start_q[idx] <= next_start;
        end
    end

endmodule

// ==== rtl/frame_rom.sv ====
`timescale 1ns/1ps

module frame_rom #(
    parameter int ROM_AW = 14
) (
    input  logic                 clk,
    input  logic                 load_en,
    input  logic [ROM_AW-1:0]    load_addr,
    input  pad_test_pkg::word_t  load_data,
    input  logic                 rd_en,
    input  logic [ROM_AW-1:0]    rd_addr,
    output pad_test_pkg::word_t  rd_data
);

    localparam int DEPTH = 2 ** ROM_AW;

    pad_test_pkg::word_t mem [0:DEPTH-1];

    // ==================================================================
    // host fill port
    // ==================================================================
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // ==================================================================
    // stream read port
    // ==================================================================
    // one cycle latency, output holds while idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== rtl/pad_test_pkg.sv ====
package pad_test_pkg;

    // ==================================================================
    // bus and field widths
    // ==================================================================
    localparam int WORD_W      = 128;
    localparam int BASE_W      = 16;
    localparam int LEN_W       = 12;
    localparam int BLK_W       = 8;
    localparam int NUM_STREAMS = 8;     // codes 0..7 are real streams
    localparam int CODE_LSB    = 18;    // code sits in bits 21:18
    localparam int ROM_AW_MIN  = 14;    // 8704 words used

    typedef logic [WORD_W-1:0] word_t;

    typedef enum logic [3:0] {
        CFG     = 4'd0,
        FLGOFM  = 4'd1,
        OFM     = 4'd2,
        WEIADDR = 4'd3,
        WEI     = 4'd4,
        FLGWEI  = 4'd5,
        ACT     = 4'd6,
        FLGACT  = 4'd7
    } stream_code_e;

    typedef enum logic [2:0] {IDLE, CONFIG, WAIT, RD_DATA} xfer_state_e;

    typedef enum logic [2:0] {IDLE_RST, CLK_OFF, RST_LOW, RST_HIGH, CLK_ON} rst_state_e;

    typedef struct packed {
        logic [BASE_W-1:0] base;    // first word of the region
        logic [LEN_W-1:0]  len;     // words per burst
        logic [BLK_W-1:0]  blocks;  // bursts before wrap
        logic              valid;
    } stream_desc_t;

    // ==================================================================
    // frame memory regions, laid out back to back
    // ==================================================================
    localparam int WEIADDR_BLK_W = 64;  // weiaddr blocks are padded out

    localparam int BASE_CFG     = 0;
    localparam int BASE_WEIADDR = BASE_CFG + 64;
    localparam int BASE_FLGWEI  = BASE_WEIADDR + WEIADDR_BLK_W * 2;
    localparam int BASE_WEI     = BASE_FLGWEI + 512 * 1;
    localparam int BASE_FLGACT  = BASE_WEI + 512 * 2;
    localparam int BASE_ACT     = BASE_FLGACT + 512 * 4;
    localparam int BASE_OFM     = BASE_ACT + 512 * 9;
    localparam int BASE_FLGOFM  = BASE_OFM + 64 * 4;

    function automatic stream_desc_t mk_desc(int base, int len, int blocks);
        mk_desc = '{base: BASE_W'(base), len: LEN_W'(len), blocks: BLK_W'(blocks),
                    valid: 1'b1};
    endfunction

    // indexed by stream code, unused codes stay invalid with zero length
    localparam stream_desc_t STREAM_DESC [16] = '{
        CFG:     mk_desc(BASE_CFG,     64,  1),
        WEIADDR: mk_desc(BASE_WEIADDR, 54,  2),
        FLGWEI:  mk_desc(BASE_FLGWEI,  512, 1),
        WEI:     mk_desc(BASE_WEI,     512, 2),
        FLGACT:  mk_desc(BASE_FLGACT,  512, 4),
        ACT:     mk_desc(BASE_ACT,     512, 9),
        OFM:     mk_desc(BASE_OFM,     64,  4),
        FLGOFM:  mk_desc(BASE_FLGOFM,  64,  1),
        default: '0
    };

endpackage
